// File: design/usb_bridge_pkg.sv
package usb_bridge_pkg;

    // ====================
    // Frame constants
    // ====================
    localparam logic [7:0] cmd_sync_0   = 8'hAA;
    localparam logic [7:0] cmd_sync_1   = 8'h55;
    localparam logic [7:0] reply_sync_0 = 8'hAA;
    localparam logic [7:0] reply_sync_1 = 8'h44;
    localparam int         max_payload  = 64;

    // Command codes, also used as reply source ids
    localparam logic [7:0] cmd_pwm    = 8'h01;
    localparam logic [7:0] cmd_sample = 8'h0B;
    localparam logic [7:0] cmd_status = 8'h0C;

    localparam int num_upload_sources = 2;
    localparam int src_idx_w          = $clog2(num_upload_sources);

    // Parser states
    localparam logic [2:0] ps_hunt    = 3'd0;
    localparam logic [2:0] ps_sync    = 3'd1;
    localparam logic [2:0] ps_cmd     = 3'd2;
    localparam logic [2:0] ps_len_hi  = 3'd3;
    localparam logic [2:0] ps_len_lo  = 3'd4;
    localparam logic [2:0] ps_payload = 3'd5;
    localparam logic [2:0] ps_csum    = 3'd6;

    // Reply serializer states
    localparam logic [2:0] rs_idle  = 3'd0;
    localparam logic [2:0] rs_sync0 = 3'd1;
    localparam logic [2:0] rs_sync1 = 3'd2;
    localparam logic [2:0] rs_src   = 3'd3;
    localparam logic [2:0] rs_len   = 3'd4;
    localparam logic [2:0] rs_pay0  = 3'd5;
    localparam logic [2:0] rs_pay1  = 3'd6;
    localparam logic [2:0] rs_csum  = 3'd7;

    // ====================
    // Bus types
    // ====================
    typedef struct packed {
        logic       start;
        logic [7:0] cmd;
        logic [5:0] index;
        logic [7:0] data;
        logic       data_valid;
        logic       done;
        logic       error;
    } cmd_bus_t;

    // First payload byte sits in the high half
    typedef struct packed {
        logic        pending;
        logic [7:0]  source;
        logic [1:0]  len;
        logic [15:0] payload;
    } upload_msg_t;

endpackage

// File: design/frame_parser.sv
`timescale 1ns/10ps

module frame_parser (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [7:0]               usb_data_in,
    input  logic                     usb_data_valid,
    output usb_bridge_pkg::cmd_bus_t cmd_bus
);

    logic        valid_d;
    logic        byte_stb;
    logic [2:0]  state;
    logic [7:0]  len_hi;
    logic [6:0]  len;
    logic [5:0]  idx;
    logic [7:0]  csum;
    logic [15:0] full_len;

    // Host strobe edge detect
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_d <= 1'b0;
        end else begin
            valid_d <= usb_data_valid;
        end
    end

    assign byte_stb = usb_data_valid & ~valid_d;
    assign full_len = {len_hi, usb_data_in};

    // ====================
    // Frame FSM
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= usb_bridge_pkg::ps_hunt;
            cmd_bus <= '0;
            len_hi  <= '0;
            len     <= '0;
            idx     <= '0;
            csum    <= '0;
        end else begin
            // Pulses last one cycle
            cmd_bus.start      <= 1'b0;
            cmd_bus.data_valid <= 1'b0;
            cmd_bus.done       <= 1'b0;
            cmd_bus.error      <= 1'b0;

            if (byte_stb) begin
                case (state)
                    usb_bridge_pkg::ps_hunt: begin
                        if (usb_data_in == usb_bridge_pkg::cmd_sync_0) begin
                            state <= usb_bridge_pkg::ps_sync;
                        end
                    end
                    usb_bridge_pkg::ps_sync: begin
                        // A wrong second byte may itself be a new first sync byte
                        if (usb_data_in == usb_bridge_pkg::cmd_sync_1) begin
                            state <= usb_bridge_pkg::ps_cmd;
                        end else if (usb_data_in != usb_bridge_pkg::cmd_sync_0) begin
                            state <= usb_bridge_pkg::ps_hunt;
                        end
                    end
                    usb_bridge_pkg::ps_cmd: begin
                        cmd_bus.cmd   <= usb_data_in;
                        cmd_bus.start <= 1'b1;
                        csum          <= usb_data_in;
                        state         <= usb_bridge_pkg::ps_len_hi;
                    end
                    usb_bridge_pkg::ps_len_hi: begin
                        len_hi <= usb_data_in;
                        csum   <= csum + usb_data_in;
                        state  <= usb_bridge_pkg::ps_len_lo;
                    end
                    usb_bridge_pkg::ps_len_lo: begin
                        csum <= csum + usb_data_in;
                        len  <= full_len[6:0];
                        idx  <= '0;
                        if (full_len > 16'(usb_bridge_pkg::max_payload)) begin
                            cmd_bus.error <= 1'b1;
                            state         <= usb_bridge_pkg::ps_hunt;
                        end else if (full_len == 16'd0) begin
                            state <= usb_bridge_pkg::ps_csum;
                        end else begin
                            state <= usb_bridge_pkg::ps_payload;
                        end
                    end
                    usb_bridge_pkg::ps_payload: begin
                        cmd_bus.data       <= usb_data_in;
                        cmd_bus.index      <= idx;
                        cmd_bus.data_valid <= 1'b1;
                        csum               <= csum + usb_data_in;
                        idx                <= idx + 6'd1;
                        if ({1'b0, idx} == len - 7'd1) begin
                            state <= usb_bridge_pkg::ps_csum;
                        end
                    end
                    usb_bridge_pkg::ps_csum: begin
                        if (usb_data_in == csum) begin
                            cmd_bus.done <= 1'b1;
                        end else begin
                            cmd_bus.error <= 1'b1;
                        end
                        state <= usb_bridge_pkg::ps_hunt;
                    end
                    default: begin
                        state <= usb_bridge_pkg::ps_hunt;
                    end
                endcase
            end
        end
    end

endmodule

// File: design/pwm_handler.sv
`timescale 1ns/10ps

module pwm_handler (
    input  logic                     clk,
    input  logic                     rst_n,
    input  usb_bridge_pkg::cmd_bus_t cmd_bus,
    output logic [7:0]               pwm_pins
);

    logic [7:0] duty [8];
    logic [7:0] shadow [8];
    logic [2:0] chan;
    logic [7:0] cnt;
    logic       is_pwm;

    // Command field is held for the whole frame
    assign is_pwm = cmd_bus.cmd == usb_bridge_pkg::cmd_pwm;

    // Shadow duties, written as channel/duty pairs
    always_ff @(posedge clk) begin
        if (cmd_bus.start && is_pwm) begin
            for (int i = 0; i < 8; i++) begin
                shadow[i] <= duty[i];
            end
        end else if (cmd_bus.data_valid && is_pwm) begin
            if (cmd_bus.index[0]) begin
                shadow[chan] <= cmd_bus.data;
            end else begin
                chan <= cmd_bus.data[2:0];
            end
        end
    end

    // Commit on a good frame, error leaves active duties alone
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                duty[i] <= '0;
            end
            cnt <= '0;
        end else begin
            cnt <= cnt + 8'd1;
            if (cmd_bus.done && is_pwm) begin
                for (int i = 0; i < 8; i++) begin
                    duty[i] <= shadow[i];
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            pwm_pins[i] = cnt < duty[i];
        end
    end

endmodule

// File: design/sampler_handler.sv
`timescale 1ns/10ps

module sampler_handler (
    input  logic                        clk,
    input  logic                        rst_n,
    input  usb_bridge_pkg::cmd_bus_t    cmd_bus,
    input  logic [7:0]                  dc_signal_in,
    input  logic                        grant,
    output usb_bridge_pkg::upload_msg_t upload
);

    logic       is_sample;
    logic       pending;
    logic [7:0] sample;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            is_sample <= 1'b0;
            pending   <= 1'b0;
        end else begin
            if (cmd_bus.start) begin
                is_sample <= cmd_bus.cmd == usb_bridge_pkg::cmd_sample;
            end
            // Query while still pending is dropped
            if (grant) begin
                pending <= 1'b0;
            end else if (cmd_bus.done && is_sample) begin
                pending <= 1'b1;
            end
        end
    end

    // Inputs captured in the done cycle
    always_ff @(posedge clk) begin
        if (cmd_bus.done && is_sample && !pending) begin
            sample <= dc_signal_in;
        end
    end

    assign upload.pending = pending;
    assign upload.source  = usb_bridge_pkg::cmd_sample;
    assign upload.len     = 2'd1;
    assign upload.payload = {sample, 8'h00};

endmodule

// File: design/status_handler.sv
`timescale 1ns/10ps

module status_handler (
    input  logic                        clk,
    input  logic                        rst_n,
    input  usb_bridge_pkg::cmd_bus_t    cmd_bus,
    input  logic                        grant,
    output usb_bridge_pkg::upload_msg_t upload
);

    logic        is_status;
    logic        pending;
    logic [7:0]  good_cnt;
    logic [7:0]  bad_cnt;
    logic [7:0]  good_next;
    logic [15:0] snapshot;

    // Saturating increment, so the query frame counts itself
    assign good_next = (good_cnt == 8'hFF) ? good_cnt : good_cnt + 8'd1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            is_status <= 1'b0;
            pending   <= 1'b0;
            good_cnt  <= '0;
            bad_cnt   <= '0;
        end else begin
            if (cmd_bus.start) begin
                is_status <= cmd_bus.cmd == usb_bridge_pkg::cmd_status;
            end
            if (cmd_bus.done) begin
                good_cnt <= good_next;
            end
            if (cmd_bus.error && bad_cnt != 8'hFF) begin
                bad_cnt <= bad_cnt + 8'd1;
            end
            if (grant) begin
                pending <= 1'b0;
            end else if (cmd_bus.done && is_status) begin
                pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_bus.done && is_status && !pending) begin
            snapshot <= {good_next, bad_cnt};
        end
    end

    assign upload.pending = pending;
    assign upload.source  = usb_bridge_pkg::cmd_status;
    assign upload.len     = 2'd2;
    assign upload.payload = snapshot;

endmodule

// File: design/upload_arbiter.sv
`timescale 1ns/10ps

module upload_arbiter (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  usb_bridge_pkg::upload_msg_t                   upload [usb_bridge_pkg::num_upload_sources],
    output logic [usb_bridge_pkg::num_upload_sources-1:0] grant,
    output logic [7:0]                                    usb_upload_data,
    output logic                                          usb_upload_valid,
    input  logic                                          usb_upload_ready
);

    logic [2:0]                           state;
    logic [usb_bridge_pkg::src_idx_w-1:0] rr_ptr;
    logic [usb_bridge_pkg::src_idx_w-1:0] sel;
    logic                                 found;
    logic                                 take;
    logic [7:0]                           msg_source;
    logic [1:0]                           msg_len;
    logic [15:0]                          msg_payload;
    logic [7:0]                           csum;

    // ====================
    // Round-robin select
    // ====================
    always_comb begin
        int cand;
        found = 1'b0;
        sel   = '0;
        for (int k = 0; k < usb_bridge_pkg::num_upload_sources; k++) begin
            cand = (int'(rr_ptr) + k) % usb_bridge_pkg::num_upload_sources;
            if (!found && upload[cand].pending) begin
                found = 1'b1;
                sel   = cand[usb_bridge_pkg::src_idx_w-1:0];
            end
        end
    end

    // Grant only while the serializer is idle
    always_comb begin
        grant = '0;
        if (state == usb_bridge_pkg::rs_idle && found) begin
            grant[sel] = 1'b1;
        end
    end

    assign usb_upload_valid = state != usb_bridge_pkg::rs_idle;
    assign take             = usb_upload_valid & usb_upload_ready;

    // Copy of the granted message
    always_ff @(posedge clk) begin
        if (|grant) begin
            msg_source  <= upload[sel].source;
            msg_len     <= upload[sel].len;
            msg_payload <= upload[sel].payload;
        end
    end

    // ====================
    // Reply serializer
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= usb_bridge_pkg::rs_idle;
            rr_ptr <= '0;
            csum   <= '0;
        end else if (|grant) begin
            state  <= usb_bridge_pkg::rs_sync0;
            rr_ptr <= (int'(sel) == usb_bridge_pkg::num_upload_sources - 1) ? '0 : sel + 1'b1;
        end else if (take) begin
            case (state)
                usb_bridge_pkg::rs_sync0: state <= usb_bridge_pkg::rs_sync1;
                usb_bridge_pkg::rs_sync1: state <= usb_bridge_pkg::rs_src;
                usb_bridge_pkg::rs_src: begin
                    csum  <= msg_source;
                    state <= usb_bridge_pkg::rs_len;
                end
                usb_bridge_pkg::rs_len: begin
                    csum  <= csum + {6'd0, msg_len};
                    state <= usb_bridge_pkg::rs_pay0;
                end
                usb_bridge_pkg::rs_pay0: begin
                    csum  <= csum + msg_payload[15:8];
                    state <= (msg_len == 2'd2) ? usb_bridge_pkg::rs_pay1 : usb_bridge_pkg::rs_csum;
                end
                usb_bridge_pkg::rs_pay1: begin
                    csum  <= csum + msg_payload[7:0];
                    state <= usb_bridge_pkg::rs_csum;
                end
                default: state <= usb_bridge_pkg::rs_idle;
            endcase
        end
    end

    // Byte stays put until accepted
    always_comb begin
        case (state)
            usb_bridge_pkg::rs_sync0: usb_upload_data = usb_bridge_pkg::reply_sync_0;
            usb_bridge_pkg::rs_sync1: usb_upload_data = usb_bridge_pkg::reply_sync_1;
            usb_bridge_pkg::rs_src:   usb_upload_data = msg_source;
            usb_bridge_pkg::rs_len:   usb_upload_data = {6'd0, msg_len};
            usb_bridge_pkg::rs_pay0:  usb_upload_data = msg_payload[15:8];
            usb_bridge_pkg::rs_pay1:  usb_upload_data = msg_payload[7:0];
            usb_bridge_pkg::rs_csum:  usb_upload_data = csum;
            default:                  usb_upload_data = 8'h00;
        endcase
    end

endmodule

// File: design/usb_bridge.sv
`timescale 1ns/10ps

module usb_bridge (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] usb_data_in,
    input  logic       usb_data_valid,
    input  logic [7:0] dc_signal_in,
    output logic [7:0] pwm_pins,
    output logic [7:0] usb_upload_data,
    output logic       usb_upload_valid,
    input  logic       usb_upload_ready
);

    usb_bridge_pkg::cmd_bus_t                      cmd_bus;
    usb_bridge_pkg::upload_msg_t                   upload [usb_bridge_pkg::num_upload_sources];
    logic [usb_bridge_pkg::num_upload_sources-1:0] grant;

    frame_parser u_frame_parser (
        .clk            (clk),
        .rst_n          (rst_n),
        .usb_data_in    (usb_data_in),
        .usb_data_valid (usb_data_valid),
        .cmd_bus        (cmd_bus)
    );

    pwm_handler u_pwm_handler (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd_bus  (cmd_bus),
        .pwm_pins (pwm_pins)
    );

    // Upload source 0 is the sampler, source 1 the status handler
    sampler_handler u_sampler_handler (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_bus      (cmd_bus),
        .dc_signal_in (dc_signal_in),
        .grant        (grant[0]),
        .upload       (upload[0])
    );

    status_handler u_status_handler (
        .clk     (clk),
        .rst_n   (rst_n),
        .cmd_bus (cmd_bus),
        .grant   (grant[1]),
        .upload  (upload[1])
    );

    upload_arbiter u_upload_arbiter (
        .clk              (clk),
        .rst_n            (rst_n),
        .upload           (upload),
        .grant            (grant),
        .usb_upload_data  (usb_upload_data),
        .usb_upload_valid (usb_upload_valid),
        .usb_upload_ready (usb_upload_ready)
    );

endmodule

// File: dv/usb_bridge_model.svh
`ifndef USB_BRIDGE_MODEL_SVH
`define USB_BRIDGE_MODEL_SVH

// Reference state of the bridge
logic [7:0] model_duty [8];
logic [7:0] model_good;
logic [7:0] model_bad;

// Payload being built, frame to send, reply bytes still expected
logic [7:0] tx_payload [$];
logic [7:0] tx_frame [$];
logic [7:0] exp_reply [$];

function automatic void model_reset();
    int i;
    for (i = 0; i < 8; i++) begin
        model_duty[i] = 8'h00;
    end
    model_good = 8'h00;
    model_bad  = 8'h00;
    tx_payload.delete();
    tx_frame.delete();
    exp_reply.delete();
endfunction

// Checksum covers command, both length bytes and payload
function automatic void build_frame(input logic [7:0] cmd, input bit corrupt);
    logic [7:0]  sum;
    logic [15:0] len;
    int          i;
    len = 16'(tx_payload.size());
    sum = cmd + len[15:8] + len[7:0];
    tx_frame.delete();
    tx_frame.push_back(usb_bridge_pkg::cmd_sync_0);
    tx_frame.push_back(usb_bridge_pkg::cmd_sync_1);
    tx_frame.push_back(cmd);
    tx_frame.push_back(len[15:8]);
    tx_frame.push_back(len[7:0]);
    for (i = 0; i < tx_payload.size(); i++) begin
        tx_frame.push_back(tx_payload[i]);
        sum += tx_payload[i];
    end
    if (corrupt) begin
        sum ^= 8'(1 + $urandom % 255);
    end
    tx_frame.push_back(sum);
endfunction

// Header only, the parser gives up after the length
function automatic void build_long_header(input int len);
    tx_frame.delete();
    tx_frame.push_back(usb_bridge_pkg::cmd_sync_0);
    tx_frame.push_back(usb_bridge_pkg::cmd_sync_1);
    tx_frame.push_back(usb_bridge_pkg::cmd_pwm);
    tx_frame.push_back(8'(len >> 8));
    tx_frame.push_back(8'(len));
endfunction

function automatic void commit_pwm();
    int i;
    for (i = 0; i + 1 < tx_payload.size(); i += 2) begin
        model_duty[tx_payload[i][2:0]] = tx_payload[i + 1];
    end
endfunction

function automatic void count_frame(input bit good);
    if (good && model_good != 8'hFF) begin
        model_good++;
    end else if (!good && model_bad != 8'hFF) begin
        model_bad++;
    end
endfunction

function automatic void push_reply(input logic [7:0] src, input logic [7:0] len,
                                   input logic [7:0] b0, input logic [7:0] b1);
    logic [7:0] sum;
    sum = src + len + b0;
    exp_reply.push_back(usb_bridge_pkg::reply_sync_0);
    exp_reply.push_back(usb_bridge_pkg::reply_sync_1);
    exp_reply.push_back(src);
    exp_reply.push_back(len);
    exp_reply.push_back(b0);
    if (len == 8'd2) begin
        exp_reply.push_back(b1);
        sum += b1;
    end
    exp_reply.push_back(sum);
endfunction

function automatic void expect_sample(input logic [7:0] value);
    push_reply(usb_bridge_pkg::cmd_sample, 8'd1, value, 8'h00);
endfunction

// Counts already include the query frame
function automatic void expect_status();
    push_reply(usb_bridge_pkg::cmd_status, 8'd2, model_good, model_bad);
endfunction

`endif

// File: dv/usb_bridge_tb.sv
`timescale 1ns/10ps

module usb_bridge_tb;

    localparam int num_frames   = 14;
    localparam int reset_cycles = 16;
    // Two PWM measurements of 50 settle plus 256 counted cycles
    localparam int limit_cycles = num_frames * 80 + 2 * (50 + 256) + reset_cycles;

    logic       clk;
    logic       rst_n;
    logic [7:0] usb_data_in;
    logic       usb_data_valid;
    logic [7:0] dc_signal_in;
    logic [7:0] pwm_pins;
    logic [7:0] usb_upload_data;
    logic       usb_upload_valid;
    logic       usb_upload_ready;

    logic       bp_on;
    int         errors;
    int         tests_ok;
    int         tests_bad;
    int         errs;
    int         npairs;
    int         k;
    int         n;
    int         seed;
    logic [7:0] b;

    // Reply collector state
    logic [7:0] rx_bytes [$];
    int         rx_frames;
    int         rx_pos;
    int         rx_len;

    `include "usb_bridge_model.svh"

    usb_bridge DUT (
        .clk              (clk),
        .rst_n            (rst_n),
        .usb_data_in      (usb_data_in),
        .usb_data_valid   (usb_data_valid),
        .dc_signal_in     (dc_signal_in),
        .pwm_pins         (pwm_pins),
        .usb_upload_data  (usb_upload_data),
        .usb_upload_valid (usb_upload_valid),
        .usb_upload_ready (usb_upload_ready)
    );

    always #20 clk = ~clk;

    // Random back-pressure only while enabled
    always @(negedge clk) begin
        usb_upload_ready <= bp_on ? 1'($urandom % 2) : 1'b1;
    end

    // ====================
    // Reply collector
    // ====================
    always @(posedge clk) begin
        if (usb_upload_valid && usb_upload_ready) begin
            rx_bytes.push_back(usb_upload_data);
            if (rx_pos == 3) begin
                rx_len = usb_upload_data;
            end
            rx_pos++;
            if (rx_pos > 4 && rx_pos == rx_len + 5) begin
                rx_frames++;
                rx_pos = 0;
            end
        end
    end

    initial begin
        repeat (limit_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, run stopped", limit_cycles);
        $display("test failed");
        $finish;
    end

    task automatic send_byte(input logic [7:0] value);
        int gap;
        gap            = 1 + $urandom % 3;
        usb_data_in    = value;
        usb_data_valid = 1'b1;
        @(negedge clk);
        usb_data_valid = 1'b0;
        repeat (gap) @(negedge clk);
    endtask

    task automatic send_frame();
        int i;
        for (i = 0; i < tx_frame.size(); i++) begin
            send_byte(tx_frame[i]);
        end
        tx_frame.delete();
    endtask

    task automatic random_pairs();
        int i;
        tx_payload.delete();
        npairs = 1 + $urandom % 4;
        for (i = 0; i < npairs; i++) begin
            tx_payload.push_back(8'($urandom));
            tx_payload.push_back(8'($urandom));
        end
    endtask

    task automatic measure_pwm();
        int high [8];
        int c;
        int p;
        for (p = 0; p < 8; p++) begin
            high[p] = 0;
        end
        repeat (50) @(negedge clk);
        for (c = 0; c < 256; c++) begin
            @(negedge clk);
            for (p = 0; p < 8; p++) begin
                if (pwm_pins[p]) begin
                    high[p]++;
                end
            end
        end
        for (p = 0; p < 8; p++) begin
            if (high[p] != int'(model_duty[p])) begin
                errors++;
                $display("FAIL t=%0t pwm_pins[%0d] high cycles expected %0d got %0d",
                         $time, p, model_duty[p], high[p]);
            end
        end
    endtask

    task automatic clear_rx();
        rx_bytes.delete();
        rx_frames = 0;
        rx_pos    = 0;
    endtask

    // Waits for n reply frames, then checks that no extra one follows
    task automatic wait_replies(input int count);
        int cyc;
        cyc = 0;
        while (rx_frames < count && cyc < 400) begin
            @(negedge clk);
            cyc++;
        end
        if (rx_frames < count) begin
            errors++;
            $display("No reply within 400 cycles, %0d of %0d frames received", rx_frames, count);
        end
        repeat (40) @(negedge clk);
        if (rx_frames != count) begin
            errors++;
            $display("Wrong number of reply frames, expected %0d, received %0d", count, rx_frames);
        end
    endtask

    task automatic compare_replies();
        int i;
        if (rx_bytes.size() != exp_reply.size()) begin
            errors++;
            $display("FAIL t=%0t usb_upload_data byte count expected %0d got %0d",
                     $time, exp_reply.size(), rx_bytes.size());
        end else begin
            for (i = 0; i < rx_bytes.size(); i++) begin
                if (rx_bytes[i] !== exp_reply[i]) begin
                    errors++;
                    $display("FAIL t=%0t usb_upload_data[%0d] expected %02h got %02h",
                             $time, i, exp_reply[i], rx_bytes[i]);
                end
            end
        end
        exp_reply.delete();
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            tests_ok++;
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", name, errors - errs_before);
        end
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        seed             = $urandom(83);
        clk              = 1'b0;
        rst_n            = 1'b0;
        usb_data_in      = 8'h00;
        usb_data_valid   = 1'b0;
        dc_signal_in     = 8'h00;
        usb_upload_ready = 1'b1;
        bp_on            = 1'b0;
        errors           = 0;
        tests_ok         = 0;
        tests_bad        = 0;
        clear_rx();
        model_reset();
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // PWM duties from a good frame
        errs = errors;
        random_pairs();
        build_frame(usb_bridge_pkg::cmd_pwm, 1'b0);
        send_frame();
        commit_pwm();
        count_frame(1'b1);
        measure_pwm();
        finish_test("pwm duties", errs);

        errs = errors;
        clear_rx();
        dc_signal_in = 8'($urandom);
        tx_payload.delete();
        build_frame(usb_bridge_pkg::cmd_sample, 1'b0);
        send_frame();
        count_frame(1'b1);
        expect_sample(dc_signal_in);
        wait_replies(1);
        compare_replies();
        finish_test("sampler reply", errs);

        // Bad checksums and an oversized length must leave the duties alone
        errs = errors;
        for (k = 0; k < 4; k++) begin
            random_pairs();
            build_frame(usb_bridge_pkg::cmd_pwm, 1'b1);
            send_frame();
            count_frame(1'b0);
        end
        build_long_header(usb_bridge_pkg::max_payload + 1 + $urandom % 200);
        send_frame();
        count_frame(1'b0);
        measure_pwm();
        finish_test("bad frames", errs);

        errs = errors;
        clear_rx();
        tx_payload.delete();
        build_frame(usb_bridge_pkg::cmd_status, 1'b0);
        send_frame();
        count_frame(1'b1);
        expect_status();
        wait_replies(1);
        compare_replies();
        finish_test("status counts", errs);

        // Both peers back to back under back-pressure
        errs = errors;
        clear_rx();
        bp_on        = 1'b1;
        dc_signal_in = 8'($urandom);
        tx_payload.delete();
        build_frame(usb_bridge_pkg::cmd_sample, 1'b0);
        send_frame();
        count_frame(1'b1);
        expect_sample(dc_signal_in);
        build_frame(usb_bridge_pkg::cmd_status, 1'b0);
        send_frame();
        count_frame(1'b1);
        expect_status();
        wait_replies(2);
        // Replies may come in either order
        if (rx_bytes.size() > 2 && rx_bytes[2] != exp_reply[2]) begin
            n = exp_reply[3] + 5;
            repeat (n) exp_reply.push_back(exp_reply.pop_front());
        end
        compare_replies();
        bp_on = 1'b0;
        finish_test("back-pressure and both peers", errs);

        // Garbage never holds the second sync byte and so cannot form a frame
        errs = errors;
        clear_rx();
        n = 4 + $urandom % 5;
        for (k = 0; k < n; k++) begin
            b = ($urandom % 3 == 0) ? usb_bridge_pkg::cmd_sync_0 : 8'($urandom);
            if (b == usb_bridge_pkg::cmd_sync_1) begin
                b = usb_bridge_pkg::cmd_sync_0;
            end
            send_byte(b);
        end
        // Stray first sync byte right before the real one
        send_byte(usb_bridge_pkg::cmd_sync_0);
        dc_signal_in = 8'($urandom);
        tx_payload.delete();
        build_frame(usb_bridge_pkg::cmd_sample, 1'b0);
        send_frame();
        count_frame(1'b1);
        expect_sample(dc_signal_in);
        wait_replies(1);
        compare_replies();
        clear_rx();
        build_frame(usb_bridge_pkg::cmd_status, 1'b0);
        send_frame();
        count_frame(1'b1);
        expect_status();
        wait_replies(1);
        compare_replies();
        finish_test("resynchronization", errs);

        $display("Tests ok: %0d, tests with errors: %0d", tests_ok, tests_bad);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: usb_bridge.f
+incdir+dv
design/usb_bridge_pkg.sv
design/frame_parser.sv
design/pwm_handler.sv
design/sampler_handler.sv
design/status_handler.sv
design/upload_arbiter.sv
design/usb_bridge.sv
dv/usb_bridge_tb.sv

// File: Bender.yml
package:
  name: usb_bridge

sources:
  - design/usb_bridge_pkg.sv
  - design/frame_parser.sv
  - design/pwm_handler.sv
  - design/sampler_handler.sv
  - design/status_handler.sv
  - design/upload_arbiter.sv
  - design/usb_bridge.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/usb_bridge_tb.sv
